// File: vlog.f
logic/vga_pkg.sv
logic/vga_timing.sv
logic/draw_bg.sv
logic/sprite_rom.sv
logic/draw_sprite.sv
logic/vga_top.sv
test/vga_checker.sv
test/tb_vga_top.sv

// File: Bender.yml
package:
  name: vga_sprite

sources:
  - files:
      - logic/vga_pkg.sv
      - logic/vga_timing.sv
      - logic/draw_bg.sv
      - logic/sprite_rom.sv
      - logic/draw_sprite.sv
      - logic/vga_top.sv
  - target: test
    files:
      - test/vga_checker.sv
      - test/tb_vga_top.sv

// File: test/tb_vga_top.sv
// Testbench on a reduced 80x46 mode with a 16x12 sprite, one test per frame
// Sprite inputs change on the falling edge after the output enters vblank
module tb_vga_top;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int H_ACTIVE      = 64;
    localparam int H_FRONT       = 4;
    localparam int H_SYNC        = 8;
    localparam int H_BACK        = 4;
    localparam int V_ACTIVE      = 40;
    localparam int V_FRONT       = 2;
    localparam int V_SYNC        = 2;
    localparam int V_BACK        = 2;
    localparam int SPRITE_WIDTH  = 16;
    localparam int SPRITE_HEIGHT = 12;
    localparam int H_TOTAL       = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL       = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam int FRAME_CYCLES  = H_TOTAL * V_TOTAL;
    localparam int NUM_TESTS     = 8;
    // Reset, the part frame after it and seven full frames, with margin
    localparam int TIMEOUT_CYCLES = NUM_TESTS * FRAME_CYCLES + 560;

    logic              clk;
    logic              rst;
    vga_pkg::pos_t     sprite_x;
    vga_pkg::pos_t     sprite_y;
    logic              sprite_en;
    vga_pkg::vga_sig_t vga_out;
    int                tests_done;
    int                error_total;
    int                cycle_count = 0;
    int                rnd_x;
    int                rnd_y;
    int                rnd_en;
    integer            seed = 32'h4ab9_4e79;

    vga_top #(
        .H_ACTIVE      (H_ACTIVE),
        .H_FRONT       (H_FRONT),
        .H_SYNC        (H_SYNC),
        .H_BACK        (H_BACK),
        .V_ACTIVE      (V_ACTIVE),
        .V_FRONT       (V_FRONT),
        .V_SYNC        (V_SYNC),
        .V_BACK        (V_BACK),
        .SPRITE_WIDTH  (SPRITE_WIDTH),
        .SPRITE_HEIGHT (SPRITE_HEIGHT)
    ) i_vga_top (
        .clk       (clk),
        .rst       (rst),
        .sprite_x  (sprite_x),
        .sprite_y  (sprite_y),
        .sprite_en (sprite_en),
        .vga_out   (vga_out)
    );

    vga_checker #(
        .H_ACTIVE      (H_ACTIVE),
        .H_FRONT       (H_FRONT),
        .H_SYNC        (H_SYNC),
        .H_TOTAL       (H_TOTAL),
        .V_ACTIVE      (V_ACTIVE),
        .V_FRONT       (V_FRONT),
        .V_SYNC        (V_SYNC),
        .V_TOTAL       (V_TOTAL),
        .SPRITE_WIDTH  (SPRITE_WIDTH),
        .SPRITE_HEIGHT (SPRITE_HEIGHT),
        .NUM_TESTS     (NUM_TESTS)
    ) i_vga_checker (
        .clk         (clk),
        .rst         (rst),
        .vga_out     (vga_out),
        .sprite_x    (sprite_x),
        .sprite_y    (sprite_y),
        .sprite_en   (sprite_en),
        .tests_done  (tests_done),
        .error_total (error_total)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic apply_sprite(input int x, input int y, input logic en);
        sprite_x  = vga_pkg::pos_t'(x);
        sprite_y  = vga_pkg::pos_t'(y);
        sprite_en = en;
    endtask

    // Returns on the falling edge where vga_out.vblnk is first seen high
    task automatic wait_vblank_start();
        logic prev;
        prev = vga_out.vblnk;
        @(negedge clk);
        while (!(vga_out.vblnk && !prev)) begin
            prev = vga_out.vblnk;
            @(negedge clk);
        end
    endtask

    // ========================================
    // Stimulus, one setting per frame
    // ========================================

    initial begin
        rst = 1'b1;
        apply_sprite(0, 0, 1'b0);
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        wait_vblank_start();
        apply_sprite(20, 10, 1'b0);
        wait_vblank_start();
        apply_sprite(20, 10, 1'b1);
        wait_vblank_start();
        // Sprite hangs over the right and bottom edges
        apply_sprite(56, 34, 1'b1);
        repeat (4) begin
            wait_vblank_start();
            rnd_x  = $unsigned($random(seed)) % 71;
            rnd_y  = $unsigned($random(seed)) % 46;
            rnd_en = $unsigned($random(seed)) % 2;
            apply_sprite(rnd_x, rnd_y, rnd_en[0]);
        end
    end

    initial begin
        wait (tests_done == NUM_TESTS);
        @(negedge clk);
        if (error_total == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("ERROR: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("sim failed");
            $finish;
        end
    end

endmodule

// File: test/vga_checker.sv
// Checks every output pixel against a model of the timing, background and sprite rules
// Sprite inputs are read at the sampling edge, so they may change only in vblank
module vga_checker #(
    parameter int H_ACTIVE      = 64,
    parameter int H_FRONT       = 4,
    parameter int H_SYNC        = 8,
    parameter int H_TOTAL       = 80,
    parameter int V_ACTIVE      = 40,
    parameter int V_FRONT       = 2,
    parameter int V_SYNC        = 2,
    parameter int V_TOTAL       = 46,
    parameter int SPRITE_WIDTH  = 16,
    parameter int SPRITE_HEIGHT = 12,
    parameter int NUM_TESTS     = 8
) (
    input  logic              clk,
    input  logic              rst,
    input  vga_pkg::vga_sig_t vga_out,
    input  vga_pkg::pos_t     sprite_x,
    input  vga_pkg::pos_t     sprite_y,
    input  logic              sprite_en,
    output int                tests_done,
    output int                error_total
);
    timeunit 1ns;
    timeprecision 1ps;

    // Cycles from the timing counters to vga_out
    localparam int LATENCY = 4;

    int                fill_count;
    int                h_exp;
    int                v_exp;
    int                test_pixels;
    int                test_errors;
    int                pixel_total;
    vga_pkg::vga_sig_t exp_px;

    // Expected stream word for pixel (h, v) with the sprite at (x, y)
    function automatic vga_pkg::vga_sig_t expected_pixel(input int h, input int v,
                                                         input int x, input int y,
                                                         input logic en);
        vga_pkg::vga_sig_t px;
        int                row;
        int                col;
        px        = '0;
        row       = v - y;
        col       = h - x;
        px.hcount = vga_pkg::count_t'(h);
        px.vcount = vga_pkg::count_t'(v);
        px.hblnk  = (h >= H_ACTIVE);
        px.vblnk  = (v >= V_ACTIVE);
        px.hsync  = (h >= H_ACTIVE + H_FRONT) && (h < H_ACTIVE + H_FRONT + H_SYNC);
        px.vsync  = (v >= V_ACTIVE + V_FRONT) && (v < V_ACTIVE + V_FRONT + V_SYNC);
        // Every fourth diagonal of the sprite is white, so see-through
        if (px.hblnk || px.vblnk) begin
            px.rgb = '0;
        end else if (en && row >= 0 && row < SPRITE_HEIGHT && col >= 0 &&
                     col < SPRITE_WIDTH && ((row + col) % 4) != 0) begin
            px.rgb = vga_pkg::rgb_t'(((row % 16) << 8) | ((col % 16) << 4) | 5);
        end else begin
            px.rgb = vga_pkg::rgb_t'((((h >> 4) % 16) << 8) | (((v >> 4) % 16) << 4) | 3);
        end
        return px;
    endfunction

    task automatic close_test();
        tests_done = tests_done + 1;
        $display("test %0d finished: %0d pixels checked, %0d errors",
                 tests_done, test_pixels, test_errors);
        if (tests_done == NUM_TESTS) begin
            $display("%0d tests done, %0d pixels checked, %0d errors",
                     tests_done, pixel_total, error_total);
        end
        test_pixels = 0;
        test_errors = 0;
    endtask

    task automatic compare_pixel();
        exp_px = expected_pixel(h_exp, v_exp, sprite_x, sprite_y, sprite_en);
        test_pixels++;
        pixel_total++;
        if (vga_out !== exp_px) begin
            $display("MISMATCH at %0d ns: pixel (%0d,%0d) expected %h got %h (rgb %h vs %h)",
                     $time, h_exp, v_exp, exp_px, vga_out, exp_px.rgb, vga_out.rgb);
            test_errors++;
            error_total++;
        end
        h_exp = (h_exp == H_TOTAL - 1) ? 0 : h_exp + 1;
        if (h_exp == 0) begin
            v_exp = (v_exp == V_TOTAL - 1) ? 0 : v_exp + 1;
        end
    endtask

    // Sampled just before the rising edge updates the DUT
    always @(posedge clk) begin
        if (rst) begin
            fill_count  = 0;
            h_exp       = 0;
            v_exp       = 0;
            test_pixels = 0;
            test_errors = 0;
            pixel_total = 0;
            error_total = 0;
            tests_done  = 0;
        end else if (fill_count < LATENCY) begin
            fill_count++;
            if (vga_out !== '0) begin
                $display("MISMATCH at %0d ns: output %h is not zero while the pipeline fills",
                         $time, vga_out);
                test_errors++;
                error_total++;
            end
        end else if (tests_done < NUM_TESTS) begin
            // A frame ends where vertical blanking starts
            if (h_exp == 0 && v_exp == V_ACTIVE) begin
                close_test();
            end
            if (tests_done < NUM_TESTS) begin
                compare_pixel();
            end
        end
    end

endmodule

// File: logic/vga_top.sv
// Timing, background and sprite stages in a chain; output lags timing by 4 clocks
// Sprite inputs are plain levels, expected to change only during vblank
module vga_top #(
    parameter int H_ACTIVE      = 800,
    parameter int H_FRONT       = 40,
    parameter int H_SYNC        = 128,
    parameter int H_BACK        = 88,
    parameter int V_ACTIVE      = 600,
    parameter int V_FRONT       = 1,
    parameter int V_SYNC        = 4,
    parameter int V_BACK        = 23,
    parameter int SPRITE_WIDTH  = 96,
    parameter int SPRITE_HEIGHT = 60
) (
    input  logic              clk,
    input  logic              rst,
    input  vga_pkg::pos_t     sprite_x,
    input  vga_pkg::pos_t     sprite_y,
    input  logic              sprite_en,
    output vga_pkg::vga_sig_t vga_out
);

    localparam int ADDR_W = $clog2(SPRITE_WIDTH * SPRITE_HEIGHT);

    vga_pkg::vga_sig_t timing_sig;
    vga_pkg::vga_sig_t bg_sig;
    vga_pkg::rgb_t     texel;
    logic [ADDR_W-1:0] texel_addr;

    vga_timing #(
        .H_ACTIVE (H_ACTIVE),
        .H_FRONT  (H_FRONT),
        .H_SYNC   (H_SYNC),
        .H_BACK   (H_BACK),
        .V_ACTIVE (V_ACTIVE),
        .V_FRONT  (V_FRONT),
        .V_SYNC   (V_SYNC),
        .V_BACK   (V_BACK)
    ) i_vga_timing (
        .clk (clk),
        .rst (rst),
        .out (timing_sig)
    );

    draw_bg i_draw_bg (
        .clk (clk),
        .rst (rst),
        .in  (timing_sig),
        .out (bg_sig)
    );

    sprite_rom #(
        .SPRITE_WIDTH  (SPRITE_WIDTH),
        .SPRITE_HEIGHT (SPRITE_HEIGHT)
    ) i_sprite_rom (
        .clk        (clk),
        .texel_addr (texel_addr),
        .texel      (texel)
    );

    draw_sprite #(
        .SPRITE_WIDTH  (SPRITE_WIDTH),
        .SPRITE_HEIGHT (SPRITE_HEIGHT)
    ) i_draw_sprite (
        .clk        (clk),
        .rst        (rst),
        .in         (bg_sig),
        .sprite_x   (sprite_x),
        .sprite_y   (sprite_y),
        .sprite_en  (sprite_en),
        .texel      (texel),
        .texel_addr (texel_addr),
        .out        (vga_out)
    );

endmodule

// File: logic/draw_sprite.sv
// Sprite overlay with three cycles of latency; white texels show the background
// Position and enable are sampled per pixel and should only change in vblank
module draw_sprite #(
    parameter int SPRITE_WIDTH  = 96,
    parameter int SPRITE_HEIGHT = 60
) (
    input  logic                                          clk,
    input  logic                                          rst,
    input  vga_pkg::vga_sig_t                             in,
    input  vga_pkg::pos_t                                 sprite_x,
    input  vga_pkg::pos_t                                 sprite_y,
    input  logic                                          sprite_en,
    input  vga_pkg::rgb_t                                 texel,
    output logic [$clog2(SPRITE_WIDTH*SPRITE_HEIGHT)-1:0] texel_addr,
    output vga_pkg::vga_sig_t                             out
);

    localparam int AREA   = SPRITE_WIDTH * SPRITE_HEIGHT;
    localparam int ADDR_W = $clog2(AREA);

    vga_pkg::vga_sig_t s1;
    vga_pkg::vga_sig_t s2;
    vga_pkg::pos_t     x1;
    vga_pkg::pos_t     y1;
    vga_pkg::pos_t     x2;
    vga_pkg::pos_t     y2;
    logic              en1;
    logic              en2;
    vga_pkg::pos_t     dx;
    vga_pkg::pos_t     dy;
    vga_pkg::rgb_t     rgb_nxt;

    // True when pixel (h, v) falls inside the sprite placed at (x, y)
    function automatic logic in_window(input vga_pkg::count_t h, input vga_pkg::count_t v,
                                       input vga_pkg::pos_t x, input vga_pkg::pos_t y);
        return (h >= x) && (h < x + SPRITE_WIDTH) &&
               (v >= y) && (v < y + SPRITE_HEIGHT);
    endfunction

    // ========================================
    // Stage 1: register input, compute address
    // ========================================

    // Offsets wrap outside the window; the result is then never used
    assign dx = vga_pkg::pos_t'(in.hcount) - sprite_x;
    assign dy = vga_pkg::pos_t'(in.vcount) - sprite_y;

    always_ff @(posedge clk) begin
        if (rst) begin
            s1         <= '0;
            x1         <= '0;
            y1         <= '0;
            en1        <= 1'b0;
            texel_addr <= '0;
        end else begin
            s1         <= in;
            x1         <= sprite_x;
            y1         <= sprite_y;
            en1        <= sprite_en;
            texel_addr <= ADDR_W'(dy * SPRITE_WIDTH + dx);
        end
    end

    // ========================================
    // Stage 2: wait for the ROM
    // ========================================

    always_ff @(posedge clk) begin
        if (rst) begin
            s2  <= '0;
            x2  <= '0;
            y2  <= '0;
            en2 <= 1'b0;
        end else begin
            s2  <= s1;
            x2  <= x1;
            y2  <= y1;
            en2 <= en1;
        end
    end

    // ========================================
    // Stage 3: choose colour
    // ========================================

    always_comb begin
        rgb_nxt = s2.rgb;
        if (en2 && !s2.hblnk && !s2.vblnk && in_window(s2.hcount, s2.vcount, x2, y2) &&
            (texel != vga_pkg::TRANSPARENT_RGB)) begin
            rgb_nxt = texel;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out <= '0;
        end else begin
            out.hcount <= s2.hcount;
            out.vcount <= s2.vcount;
            out.hsync  <= s2.hsync;
            out.vsync  <= s2.vsync;
            out.hblnk  <= s2.hblnk;
            out.vblnk  <= s2.vblnk;
            out.rgb    <= rgb_nxt;
        end
    end

    // Address sent to the ROM must hit the sprite for in-window pixels
    a_addr_in_area: assert property (
        @(posedge clk) disable iff (rst)
        in_window(s1.hcount, s1.vcount, x1, y1) |-> (texel_addr < AREA)
    );

endmodule

// File: logic/sprite_rom.sv
// Sprite texel memory with one clock of read latency
// Addresses past the sprite area return undefined data
module sprite_rom #(
    parameter int SPRITE_WIDTH  = 96,
    parameter int SPRITE_HEIGHT = 60
) (
    input  logic                                          clk,
    input  logic [$clog2(SPRITE_WIDTH*SPRITE_HEIGHT)-1:0] texel_addr,
    output vga_pkg::rgb_t                                 texel
);

    localparam int AREA = SPRITE_WIDTH * SPRITE_HEIGHT;

    vga_pkg::rgb_t rom [AREA];

    // Row-major fill: address = row * width + column
    initial begin
        for (int i = 0; i < AREA; i++) begin
            rom[i] = vga_pkg::sprite_texel(i / SPRITE_WIDTH, i % SPRITE_WIDTH);
        end
    end

    always_ff @(posedge clk) begin
        texel <= rom[texel_addr];
    end

endmodule

// File: logic/draw_bg.sv
// Background painter with one cycle of latency
// Pattern uses counter bits 7..4, so it repeats every 256 pixels and lines
module draw_bg (
    input  logic              clk,
    input  logic              rst,
    input  vga_pkg::vga_sig_t in,
    output vga_pkg::vga_sig_t out
);

    vga_pkg::rgb_t rgb_nxt;

    // Colour pattern in active video, black in blanking
    always_comb begin
        if (in.hblnk || in.vblnk) begin
            rgb_nxt = '0;
        end else begin
            rgb_nxt = {in.hcount[7:4], in.vcount[7:4], 4'h3};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out <= '0;
        end else begin
            out.hcount <= in.hcount;
            out.vcount <= in.vcount;
            out.hsync  <= in.hsync;
            out.vsync  <= in.vsync;
            out.hblnk  <= in.hblnk;
            out.vblnk  <= in.vblnk;
            out.rgb    <= rgb_nxt;
        end
    end

endmodule

// File: logic/vga_timing.sv
// Counters, sync and blanking for one video mode; sync pulses are active high
// All outputs are registered and start from zero after reset
module vga_timing #(
    parameter int H_ACTIVE = 800,
    parameter int H_FRONT  = 40,
    parameter int H_SYNC   = 128,
    parameter int H_BACK   = 88,
    parameter int V_ACTIVE = 600,
    parameter int V_FRONT  = 1,
    parameter int V_SYNC   = 4,
    parameter int V_BACK   = 23
) (
    input  logic              clk,
    input  logic              rst,
    output vga_pkg::vga_sig_t out
);

    localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

    vga_pkg::count_t hcount_nxt;
    vga_pkg::count_t vcount_nxt;

    // ========================================
    // Next counter values
    // ========================================

    always_comb begin
        if (out.hcount == vga_pkg::count_t'(H_TOTAL - 1)) begin
            hcount_nxt = '0;
            if (out.vcount == vga_pkg::count_t'(V_TOTAL - 1)) begin
                vcount_nxt = '0;
            end else begin
                vcount_nxt = out.vcount + 1'b1;
            end
        end else begin
            hcount_nxt = out.hcount + 1'b1;
            vcount_nxt = out.vcount;
        end
    end

    // ========================================
    // Registered stream
    // ========================================

    // Flags are decoded from the next count so they line up with it
    always_ff @(posedge clk) begin
        if (rst) begin
            out <= '0;
        end else begin
            out.hcount <= hcount_nxt;
            out.vcount <= vcount_nxt;
            out.hblnk  <= (hcount_nxt >= H_ACTIVE);
            out.hsync  <= (hcount_nxt >= H_ACTIVE + H_FRONT) &&
                          (hcount_nxt <  H_ACTIVE + H_FRONT + H_SYNC);
            out.vblnk  <= (vcount_nxt >= V_ACTIVE);
            out.vsync  <= (vcount_nxt >= V_ACTIVE + V_FRONT) &&
                          (vcount_nxt <  V_ACTIVE + V_FRONT + V_SYNC);
            out.rgb    <= '0;
        end
    end

    a_hcount_range: assert property (
        @(posedge clk) disable iff (rst)
        out.hcount < H_TOTAL
    );

endmodule

// File: logic/vga_pkg.sv
// Shared types for the pixel stream; one pixel per clock, no handshake
// Sprite texels come from a fixed rule so no image file is needed
package vga_pkg;

    localparam int COUNT_W = 11;
    localparam int POS_W   = 12;
    localparam int RGB_W   = 12;

    typedef logic [RGB_W-1:0]   rgb_t;
    typedef logic [COUNT_W-1:0] count_t;
    typedef logic [POS_W-1:0]   pos_t;

    // One pixel of the video stream
    typedef struct packed {
        count_t hcount;
        count_t vcount;
        logic   hsync;
        logic   vsync;
        logic   hblnk;
        logic   vblnk;
        rgb_t   rgb;
    } vga_sig_t;

    // Texels of this colour are see-through
    localparam rgb_t TRANSPARENT_RGB = 12'hFFF;

    // ========================================
    // Sprite texel rule
    // ========================================

    // White on every fourth diagonal, else a row/column colour ramp
    function automatic rgb_t sprite_texel(input int unsigned row, input int unsigned col);
        rgb_t texel;
        if (((row + col) % 4) == 0) begin
            texel = TRANSPARENT_RGB;
        end else begin
            texel = {row[3:0], col[3:0], 4'h5};
        end
        return texel;
    endfunction

endpackage
